//--- qspi_csr_pkg.sv
// Shared address map, register layouts, write masks and reset values for the QSPI CSR block
`default_nettype none

package qspi_csr_pkg;

  localparam int DATA_W   = 32;
  // Only the low offset bits take part in register decode
  localparam int OFFSET_W = 12;

  typedef enum logic [3:0] {
    REG_ID,
    REG_CTRL,
    REG_STATUS,
    REG_INT_EN,
    REG_INT_STAT,
    REG_CLK_DIV,
    REG_CS_CTRL,
    REG_CMD_CFG,
    REG_CMD_OP,
    REG_CMD_ADDR,
    REG_CMD_LEN,
    REG_FIFO_TX,
    REG_FIFO_RX,
    REG_FIFO_STAT,
    REG_NONE
  } reg_sel_t;

  // ------------------------------------------------------------
  // Address map, packed without gaps
  // ------------------------------------------------------------
  localparam logic [OFFSET_W-1:0] ADDR_ID        = 12'h000;
  localparam logic [OFFSET_W-1:0] ADDR_CTRL      = 12'h004;
  localparam logic [OFFSET_W-1:0] ADDR_STATUS    = 12'h008;
  localparam logic [OFFSET_W-1:0] ADDR_INT_EN    = 12'h00C;
  localparam logic [OFFSET_W-1:0] ADDR_INT_STAT  = 12'h010;
  localparam logic [OFFSET_W-1:0] ADDR_CLK_DIV   = 12'h014;
  localparam logic [OFFSET_W-1:0] ADDR_CS_CTRL   = 12'h018;
  localparam logic [OFFSET_W-1:0] ADDR_CMD_CFG   = 12'h01C;
  localparam logic [OFFSET_W-1:0] ADDR_CMD_OP    = 12'h020;
  localparam logic [OFFSET_W-1:0] ADDR_CMD_ADDR  = 12'h024;
  localparam logic [OFFSET_W-1:0] ADDR_CMD_LEN   = 12'h028;
  localparam logic [OFFSET_W-1:0] ADDR_FIFO_TX   = 12'h02C;
  localparam logic [OFFSET_W-1:0] ADDR_FIFO_RX   = 12'h030;
  localparam logic [OFFSET_W-1:0] ADDR_FIFO_STAT = 12'h034;

  localparam logic [DATA_W-1:0] ID_VALUE = 32'h1A00_1081;

  // ------------------------------------------------------------
  // Register layouts
  // ------------------------------------------------------------
  typedef struct packed {
    logic [31:10] rsvd_hi;
    logic         hold_en;
    logic         cmd_trigger;  // write-only, reads 0
    logic [7:6]   rsvd_mid;
    logic         lsb_first;
    logic         cpha;
    logic         cpol;
    logic         quad_en;
    logic         rsvd_lo;
    logic         enable;
  } ctrl_t;

  typedef struct packed {
    logic [31:3] rsvd;
    logic [2:0]  div;
  } clk_div_t;

  typedef struct packed {
    logic [31:5] rsvd;
    logic [1:0]  cs_delay;
    logic [1:0]  cs_level;
    logic        cs_auto;
  } cs_ctrl_t;

  typedef struct packed {
    logic [31:14] rsvd;
    logic         mode_en;
    logic         is_write;
    logic [3:0]   dummy_cycles;
    logic [1:0]   addr_bytes;
    logic [1:0]   data_lanes;
    logic [1:0]   addr_lanes;
    logic [1:0]   cmd_lanes;
  } cmd_cfg_t;

  typedef struct packed {
    logic [31:16] rsvd;
    logic [7:0]   mode_bits;
    logic [7:0]   opcode;
  } cmd_op_t;

  // Same bit order as qspi_events_t so a set pulse maps straight onto its status bit
  typedef struct packed {
    logic rx_full;
    logic tx_empty;
    logic cmd_done;
  } int_vec_t;

  typedef struct packed {
    logic rx_full_set;
    logic tx_empty_set;
    logic cmd_done_set;
  } qspi_events_t;

  // Laid out as the low bits of the FIFO_STAT word
  typedef struct packed {
    logic       rx_full;
    logic       tx_empty;
    logic [3:0] rx_level;
    logic [3:0] tx_level;
  } fifo_status_t;

  localparam logic [DATA_W-1:0] CTRL_WMASK    = 32'h0000_023D;
  localparam logic [DATA_W-1:0] CLK_DIV_WMASK = 32'h0000_0007;
  localparam logic [DATA_W-1:0] CS_CTRL_WMASK = 32'h0000_001F;
  localparam logic [DATA_W-1:0] CS_CTRL_RESET = 32'h0000_0001;
  localparam logic [DATA_W-1:0] CMD_CFG_WMASK = 32'h0000_3FFF;
  localparam logic [DATA_W-1:0] CMD_OP_WMASK  = 32'h0000_FFFF;
  localparam logic [DATA_W-1:0] INT_EN_WMASK  = 32'h0000_0007;

  // Expand byte strobes into a bit mask
  function automatic logic [DATA_W-1:0] strb_mask(input logic [DATA_W/8-1:0] strb);
    logic [DATA_W-1:0] m;
    for (int i = 0; i < DATA_W / 8; i++) begin
      m[8*i +: 8] = {8{strb[i]}};
    end
    return m;
  endfunction

endpackage

`default_nettype wire

//--- apb_decode.sv
// APB access decode: turns the address into a register select, write/read enables and PSLVERR
`timescale 1ns/1ps
`default_nettype none

module apb_decode #(
  parameter int ADDR_W = 12  // must cover the decoded offset bits
) (
  input  wire                                 pclk,
  input  wire                                 presetn,
  input  wire                                 psel_i,
  input  wire                                 penable_i,
  input  wire                                 pwrite_i,
  input  wire [ADDR_W-1:0]                    paddr_i,
  input  wire [qspi_csr_pkg::DATA_W/8-1:0]    pstrb_i,
  input  wire                                 trig_lockout_i,
  output qspi_csr_pkg::reg_sel_t              reg_sel_o,
  output logic                                wr_en_o,
  output logic                                rd_en_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  output logic                                fifo_tx_we_o
);
  import qspi_csr_pkg::*;

  logic [OFFSET_W-1:0] offset;
  logic                access;
  logic                writable;

  assign offset = paddr_i[OFFSET_W-1:0];
  assign access = psel_i & penable_i;

  always_comb begin
    case (offset)
      ADDR_ID:        reg_sel_o = REG_ID;
      ADDR_CTRL:      reg_sel_o = REG_CTRL;
      ADDR_STATUS:    reg_sel_o = REG_STATUS;
      ADDR_INT_EN:    reg_sel_o = REG_INT_EN;
      ADDR_INT_STAT:  reg_sel_o = REG_INT_STAT;
      ADDR_CLK_DIV:   reg_sel_o = REG_CLK_DIV;
      ADDR_CS_CTRL:   reg_sel_o = REG_CS_CTRL;
      ADDR_CMD_CFG:   reg_sel_o = REG_CMD_CFG;
      ADDR_CMD_OP:    reg_sel_o = REG_CMD_OP;
      ADDR_CMD_ADDR:  reg_sel_o = REG_CMD_ADDR;
      ADDR_CMD_LEN:   reg_sel_o = REG_CMD_LEN;
      ADDR_FIFO_TX:   reg_sel_o = REG_FIFO_TX;
      ADDR_FIFO_RX:   reg_sel_o = REG_FIFO_RX;
      ADDR_FIFO_STAT: reg_sel_o = REG_FIFO_STAT;
      default:        reg_sel_o = REG_NONE;
    endcase
  end

  // STATUS stays writable for its done-bit clear
  assign writable = !(reg_sel_o inside {REG_ID, REG_FIFO_RX, REG_FIFO_STAT, REG_NONE});

  // Zero wait state, every transfer ends in its access phase
  assign pready_o     = 1'b1;
  assign wr_en_o      = access & pwrite_i & writable;
  assign rd_en_o      = access & ~pwrite_i & (reg_sel_o != REG_NONE);
  assign pslverr_o    = access & pwrite_i & (~writable | trig_lockout_i);
  assign fifo_tx_we_o = wr_en_o & (reg_sel_o == REG_FIFO_TX);

  // ------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------
  a_penable_needs_psel: assert property (
    @(posedge pclk) disable iff (!presetn) penable_i |-> psel_i);

  a_wr_rd_exclusive: assert property (
    @(posedge pclk) disable iff (!presetn) !(wr_en_o && rd_en_o));

  // Setup-phase controls must hold into the access phase
  a_setup_stable: assert property (
    @(posedge pclk) disable iff (!presetn)
    (psel_i && !penable_i) |=> ($stable(paddr_i) && $stable(pwrite_i) && $stable(pstrb_i)));

endmodule

`default_nettype wire

//--- csr_field_reg.sv
// Byte-strobed, write-masked configuration register; one instance per plain CSR
`timescale 1ns/1ps
`default_nettype none

module csr_field_reg #(
  parameter type                    T         = logic [31:0],
  parameter qspi_csr_pkg::reg_sel_t SEL       = qspi_csr_pkg::REG_NONE,
  parameter logic [31:0]            WMASK     = 32'hFFFF_FFFF,
  parameter logic [31:0]            RESET_VAL = 32'h0000_0000
) (
  input  wire                              pclk,
  input  wire                              presetn,
  input  qspi_csr_pkg::reg_sel_t           reg_sel_i,
  input  wire                              wr_en_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   pwdata_i,
  input  wire [qspi_csr_pkg::DATA_W/8-1:0] pstrb_i,
  output T                                 q_o
);
  import qspi_csr_pkg::*;

  logic [DATA_W-1:0] q_r;
  logic [DATA_W-1:0] bit_en;

  // Only bits that are both strobed and writable change
  assign bit_en = strb_mask(pstrb_i) & WMASK;

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      q_r <= RESET_VAL;
    end else if (wr_en_i && (reg_sel_i == SEL)) begin
      q_r <= (q_r & ~bit_en) | (pwdata_i & bit_en);
    end
  end

  assign q_o = T'(q_r[$bits(T)-1:0]);

endmodule

`default_nettype wire

//--- ctrl_trigger.sv
// CTRL register with the write-one-to-start command trigger and its busy lockout
`timescale 1ns/1ps
`default_nettype none

module ctrl_trigger (
  input  wire                              pclk,
  input  wire                              presetn,
  input  qspi_csr_pkg::reg_sel_t           reg_sel_i,
  input  wire                              wr_en_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   pwdata_i,
  input  wire [qspi_csr_pkg::DATA_W/8-1:0] pstrb_i,
  input  wire                              busy_i,
  input  wire                              cmd_trigger_clr_i,
  output qspi_csr_pkg::ctrl_t              ctrl_o,
  output logic                             cmd_start_o,
  output logic                             trig_lockout_o
);
  import qspi_csr_pkg::*;

  ctrl_t             ctrl_q;
  ctrl_t             ctrl_next;
  logic [DATA_W-1:0] bit_en;
  logic              ctrl_wr;
  logic              trig_wr;
  logic              trig_ok;
  logic              trig_q;

  assign ctrl_wr = wr_en_i && (reg_sel_i == REG_CTRL);
  assign bit_en  = strb_mask(pstrb_i) & CTRL_WMASK;

  // Value after this write, so enable and trigger may share one transfer
  assign ctrl_next = ctrl_wr ? ctrl_t'((ctrl_q & ~bit_en) | (pwdata_i & bit_en)) : ctrl_q;

  assign trig_wr        = ctrl_wr && pstrb_i[1] && pwdata_i[8];
  assign trig_ok        = trig_wr && ctrl_next.enable && !busy_i;
  assign trig_lockout_o = trig_wr && busy_i;

  // cmd_trigger sits outside the mask and is never stored
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_next;
    end
  end

  // Start request, held until the command engine acknowledges
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      trig_q <= 1'b0;
    end else if (cmd_trigger_clr_i) begin
      trig_q <= 1'b0;
    end else if (trig_ok) begin
      trig_q <= 1'b1;
    end
  end

  assign ctrl_o      = ctrl_q;
  assign cmd_start_o = trig_q;

  a_start_needs_enable: assert property (
    @(posedge pclk) disable iff (!presetn) $rose(cmd_start_o) |-> ctrl_q.enable);

endmodule

`default_nettype wire

//--- event_status.sv
// Sticky interrupt status, command-done latch and the interrupt line
`timescale 1ns/1ps
`default_nettype none

module event_status (
  input  wire                              pclk,
  input  wire                              presetn,
  input  qspi_csr_pkg::reg_sel_t           reg_sel_i,
  input  wire                              wr_en_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   pwdata_i,
  input  wire [qspi_csr_pkg::DATA_W/8-1:0] pstrb_i,
  input  qspi_csr_pkg::qspi_events_t       events_i,
  input  qspi_csr_pkg::int_vec_t           int_en_i,
  output qspi_csr_pkg::int_vec_t           int_stat_o,
  output logic                             cmd_done_o,
  output logic                             irq_o
);
  import qspi_csr_pkg::*;

  int_vec_t int_stat_q;
  int_vec_t set_vec;
  int_vec_t clr_vec;
  logic     done_q;
  logic     done_clr;

  assign set_vec = int_vec_t'(events_i);

  // Write-one-to-clear, all three bits live in byte 0
  assign clr_vec = (wr_en_i && (reg_sel_i == REG_INT_STAT) && pstrb_i[0]) ?
                   int_vec_t'(pwdata_i[2:0]) : int_vec_t'(3'b000);

  assign done_clr = wr_en_i && (reg_sel_i == REG_STATUS) && pstrb_i[0] && pwdata_i[0];

  // A set in the same cycle as a clear wins
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      int_stat_q <= '0;
      done_q     <= 1'b0;
    end else begin
      int_stat_q <= int_vec_t'((int_stat_q & ~clr_vec) | set_vec);
      done_q     <= events_i.cmd_done_set | (done_q & ~done_clr);
    end
  end

  assign int_stat_o = int_stat_q;
  assign cmd_done_o = done_q;
  assign irq_o      = |(int_en_i & int_stat_q);

endmodule

`default_nettype wire

//--- read_return.sv
// Read data mux for all registers and the single-pop control of the RX FIFO window
`timescale 1ns/1ps
`default_nettype none

module read_return (
  input  wire                              pclk,
  input  wire                              presetn,
  input  wire                              psel_i,
  input  qspi_csr_pkg::reg_sel_t           reg_sel_i,
  input  wire                              rd_en_i,
  input  qspi_csr_pkg::ctrl_t              ctrl_i,
  input  qspi_csr_pkg::clk_div_t           clk_div_i,
  input  qspi_csr_pkg::cs_ctrl_t           cs_ctrl_i,
  input  qspi_csr_pkg::cmd_cfg_t           cmd_cfg_i,
  input  qspi_csr_pkg::cmd_op_t            cmd_op_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   cmd_addr_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   cmd_len_i,
  input  qspi_csr_pkg::int_vec_t           int_en_i,
  input  qspi_csr_pkg::int_vec_t           int_stat_i,
  input  wire                              cmd_done_i,
  input  wire                              busy_i,
  input  qspi_csr_pkg::fifo_status_t       fifo_status_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   fifo_rx_data_i,
  output logic [qspi_csr_pkg::DATA_W-1:0]  prdata_o,
  output logic                             fifo_rx_re_o
);
  import qspi_csr_pkg::*;

  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] fifo_stat_word;
  logic              rx_rd;
  logic              pop_seen;

  assign status_word = {20'd0, fifo_status_i.rx_level, fifo_status_i.tx_level,
                        2'b00, busy_i, cmd_done_i};
  assign fifo_stat_word = {22'd0, fifo_status_i};

  // Zero outside a read access phase; FIFO_TX is write only
  always_comb begin
    prdata_o = '0;
    if (rd_en_i) begin
      case (reg_sel_i)
        REG_ID:        prdata_o = ID_VALUE;
        REG_CTRL:      prdata_o = ctrl_i;
        REG_STATUS:    prdata_o = status_word;
        REG_INT_EN:    prdata_o = {29'd0, int_en_i};
        REG_INT_STAT:  prdata_o = {29'd0, int_stat_i};
        REG_CLK_DIV:   prdata_o = clk_div_i;
        REG_CS_CTRL:   prdata_o = cs_ctrl_i;
        REG_CMD_CFG:   prdata_o = cmd_cfg_i;
        REG_CMD_OP:    prdata_o = cmd_op_i;
        REG_CMD_ADDR:  prdata_o = cmd_addr_i;
        REG_CMD_LEN:   prdata_o = cmd_len_i;
        REG_FIFO_RX:   prdata_o = fifo_rx_data_i;
        REG_FIFO_STAT: prdata_o = fifo_stat_word;
        default:       prdata_o = '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // RX window pop, once per streak of FIFO_RX reads
  // ------------------------------------------------------------
  assign rx_rd = rd_en_i && (reg_sel_i == REG_FIFO_RX);

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      pop_seen <= 1'b0;
    end else if (rx_rd) begin
      pop_seen <= 1'b1;
    end else if (psel_i && (reg_sel_i != REG_FIFO_RX)) begin
      pop_seen <= 1'b0;
    end
  end

  assign fifo_rx_re_o = rx_rd && !pop_seen;

  a_single_cycle_pop: assert property (
    @(posedge pclk) disable iff (!presetn) fifo_rx_re_o |=> !fifo_rx_re_o);

endmodule

`default_nettype wire

//--- qspi_csr_top.sv
// Top of the QSPI APB register block; connects decode, register stages and read return
`timescale 1ns/1ps
`default_nettype none

module qspi_csr_top #(
  parameter int ADDR_W = 12
) (
  input  wire                              pclk,
  input  wire                              presetn,
  input  wire                              psel_i,
  input  wire                              penable_i,
  input  wire                              pwrite_i,
  input  wire [ADDR_W-1:0]                 paddr_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   pwdata_i,
  input  wire [qspi_csr_pkg::DATA_W/8-1:0] pstrb_i,
  output logic [qspi_csr_pkg::DATA_W-1:0]  prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  wire                              busy_i,
  input  wire                              cmd_trigger_clr_i,
  input  qspi_csr_pkg::qspi_events_t       events_i,
  input  qspi_csr_pkg::fifo_status_t       fifo_status_i,
  input  wire [qspi_csr_pkg::DATA_W-1:0]   fifo_rx_data_i,
  output qspi_csr_pkg::ctrl_t              ctrl_o,
  output qspi_csr_pkg::clk_div_t           clk_div_o,
  output qspi_csr_pkg::cs_ctrl_t           cs_ctrl_o,
  output qspi_csr_pkg::cmd_cfg_t           cmd_cfg_o,
  output qspi_csr_pkg::cmd_op_t            cmd_op_o,
  output logic [qspi_csr_pkg::DATA_W-1:0]  cmd_addr_o,
  output logic [qspi_csr_pkg::DATA_W-1:0]  cmd_len_o,
  output logic                             cmd_start_o,
  output logic                             fifo_tx_we_o,
  output logic [qspi_csr_pkg::DATA_W-1:0]  fifo_tx_data_o,
  output logic                             fifo_rx_re_o,
  output logic                             irq_o
);
  import qspi_csr_pkg::*;

  reg_sel_t reg_sel;
  logic     wr_en;
  logic     rd_en;
  logic     trig_lockout;
  int_vec_t int_en;
  int_vec_t int_stat;
  logic     cmd_done;

  assign fifo_tx_data_o = pwdata_i;

  // ------------------------------------------------------------
  // Decode and control stages
  // ------------------------------------------------------------
  apb_decode #(.ADDR_W(ADDR_W)) u_decode (
    .pclk, .presetn, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pstrb_i,
    .trig_lockout_i(trig_lockout), .reg_sel_o(reg_sel), .wr_en_o(wr_en),
    .rd_en_o(rd_en), .pready_o, .pslverr_o, .fifo_tx_we_o
  );

  ctrl_trigger u_ctrl (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .busy_i, .cmd_trigger_clr_i, .ctrl_o, .cmd_start_o, .trig_lockout_o(trig_lockout)
  );

  event_status u_events (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .events_i, .int_en_i(int_en), .int_stat_o(int_stat), .cmd_done_o(cmd_done), .irq_o
  );

  // Plain configuration registers
  csr_field_reg #(.T(clk_div_t), .SEL(REG_CLK_DIV), .WMASK(CLK_DIV_WMASK)) u_clk_div (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(clk_div_o)
  );

  csr_field_reg #(.T(cs_ctrl_t), .SEL(REG_CS_CTRL), .WMASK(CS_CTRL_WMASK),
                  .RESET_VAL(CS_CTRL_RESET)) u_cs_ctrl (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(cs_ctrl_o)
  );

  csr_field_reg #(.T(cmd_cfg_t), .SEL(REG_CMD_CFG), .WMASK(CMD_CFG_WMASK)) u_cmd_cfg (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(cmd_cfg_o)
  );

  csr_field_reg #(.T(cmd_op_t), .SEL(REG_CMD_OP), .WMASK(CMD_OP_WMASK)) u_cmd_op (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(cmd_op_o)
  );

  csr_field_reg #(.T(logic [DATA_W-1:0]), .SEL(REG_CMD_ADDR)) u_cmd_addr (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(cmd_addr_o)
  );

  csr_field_reg #(.T(logic [DATA_W-1:0]), .SEL(REG_CMD_LEN)) u_cmd_len (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(cmd_len_o)
  );

  csr_field_reg #(.T(int_vec_t), .SEL(REG_INT_EN), .WMASK(INT_EN_WMASK)) u_int_en (
    .pclk, .presetn, .reg_sel_i(reg_sel), .wr_en_i(wr_en), .pwdata_i, .pstrb_i,
    .q_o(int_en)
  );

  // Read data path
  read_return u_read (
    .pclk, .presetn, .psel_i, .reg_sel_i(reg_sel), .rd_en_i(rd_en),
    .ctrl_i(ctrl_o), .clk_div_i(clk_div_o), .cs_ctrl_i(cs_ctrl_o),
    .cmd_cfg_i(cmd_cfg_o), .cmd_op_i(cmd_op_o), .cmd_addr_i(cmd_addr_o),
    .cmd_len_i(cmd_len_o), .int_en_i(int_en), .int_stat_i(int_stat),
    .cmd_done_i(cmd_done), .busy_i, .fifo_status_i, .fifo_rx_data_i,
    .prdata_o, .fifo_rx_re_o
  );

endmodule

`default_nettype wire

//--- tb_qspi_csr.sv
// Self-checking testbench for the QSPI APB register block; top of the simulation run
`timescale 1ns/1ps
`default_nettype none

module tb_qspi_csr;
  import qspi_csr_pkg::*;

  localparam int TIMEOUT_CYC = 16;

  logic         pclk;
  logic         presetn;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [11:0]  paddr;
  logic [31:0]  pwdata;
  logic [3:0]   pstrb;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic         busy;
  logic         trig_clr;
  qspi_events_t events;
  fifo_status_t fifo_st;
  logic [31:0]  rx_data;
  ctrl_t        ctrl;
  clk_div_t     clk_div;
  cs_ctrl_t     cs_ctrl;
  cmd_cfg_t     cmd_cfg;
  cmd_op_t      cmd_op;
  logic [31:0]  cmd_addr;
  logic [31:0]  cmd_len;
  logic         cmd_start;
  logic         tx_we;
  logic [31:0]  tx_data;
  logic         rx_re;
  logic         irq;

  // Register model indexed by word offset
  logic [31:0] model [16];
  logic [31:0] wmask [16];
  logic [2:0]  exp_int_stat;
  logic        exp_done;

  // Captured in the access phase of the last transfer
  logic [31:0] last_rdata;
  logic        last_err;
  logic        last_tx_we;
  logic [31:0] last_tx_data;
  logic        last_rx_re;

  int mismatch_cnt;
  int fail_cnt;

  qspi_csr_top #(.ADDR_W(12)) uut (
    .pclk(pclk), .presetn(presetn), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .busy_i(busy), .cmd_trigger_clr_i(trig_clr), .events_i(events),
    .fifo_status_i(fifo_st), .fifo_rx_data_i(rx_data),
    .ctrl_o(ctrl), .clk_div_o(clk_div), .cs_ctrl_o(cs_ctrl), .cmd_cfg_o(cmd_cfg),
    .cmd_op_o(cmd_op), .cmd_addr_o(cmd_addr), .cmd_len_o(cmd_len),
    .cmd_start_o(cmd_start), .fifo_tx_we_o(tx_we), .fifo_tx_data_o(tx_data),
    .fifo_rx_re_o(rx_re), .irq_o(irq)
  );

  always #2 pclk = ~pclk;

  // ------------------------------------------------------------
  // Protocol checks on every cycle
  // ------------------------------------------------------------
  a_pready_high: assert property (@(posedge pclk) disable iff (!presetn) pready)
    else begin
      mismatch_cnt++;
      $display("Mismatch pready_o: got 0x%0h expected 0x1", $sampled(pready));
    end

  a_prdata_idle: assert property (@(posedge pclk) disable iff (!presetn)
    !(psel && penable && !pwrite) |-> (prdata == 32'h0))
    else begin
      mismatch_cnt++;
      $display("Mismatch prdata_o: got 0x%08h expected 0x00000000", $sampled(prdata));
    end

  a_err_on_write: assert property (@(posedge pclk) disable iff (!presetn)
    pslverr |-> (psel && penable && pwrite))
    else begin
      fail_cnt++;
      $display("PSLVERR was raised outside a write access phase");
    end

  a_tx_push: assert property (@(posedge pclk) disable iff (!presetn)
    tx_we |-> (psel && penable && pwrite && paddr == ADDR_FIFO_TX && tx_data == pwdata))
    else begin
      fail_cnt++;
      $display("TX FIFO push seen outside a FIFO_TX write or with the wrong data");
    end

  a_rx_pop: assert property (@(posedge pclk) disable iff (!presetn)
    rx_re |-> (psel && penable && !pwrite && paddr == ADDR_FIFO_RX))
    else begin
      fail_cnt++;
      $display("RX FIFO pop seen outside a FIFO_RX read");
    end

  // ------------------------------------------------------------
  // Model and check helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    logic [31:0] m;
    m = 32'h0;
    if (strb[0]) m[7:0] = 8'hFF;
    if (strb[1]) m[15:8] = 8'hFF;
    if (strb[2]) m[23:16] = 8'hFF;
    if (strb[3]) m[31:24] = 8'hFF;
    return m;
  endfunction

  function automatic logic [31:0] expected_read(input logic [3:0] idx);
    logic [31:0] w;
    w = 32'h0;
    case (idx)
      4'd2: begin
        w[0] = exp_done;
        w[1] = busy;
        w[7:4] = fifo_st.tx_level;
        w[11:8] = fifo_st.rx_level;
      end
      4'd4: w[2:0] = exp_int_stat;
      4'd12: w = rx_data;
      4'd13: begin
        w[3:0] = fifo_st.tx_level;
        w[7:4] = fifo_st.rx_level;
        w[8] = fifo_st.tx_empty;
        w[9] = fifo_st.rx_full;
      end
      default: w = model[idx];
    endcase
    return w;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
      model[i] = 32'h0;
      wmask[i] = 32'h0;
    end
    model[0] = 32'h1A00_1081;
    model[6] = CS_CTRL_RESET;
    wmask[1] = CTRL_WMASK;
    wmask[3] = INT_EN_WMASK;
    wmask[5] = CLK_DIV_WMASK;
    wmask[6] = CS_CTRL_WMASK;
    wmask[7] = CMD_CFG_WMASK;
    wmask[8] = CMD_OP_WMASK;
    wmask[9] = 32'hFFFF_FFFF;
    wmask[10] = 32'hFFFF_FFFF;
    exp_int_stat = 3'b000;
    exp_done = 1'b0;
  endtask

  task automatic model_write(input logic [3:0] idx, input logic [31:0] data,
                             input logic [3:0] strb);
    logic [31:0] m;
    m = lane_mask(strb) & wmask[idx];
    model[idx] = (model[idx] & ~m) | (data & m);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      mismatch_cnt++;
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_val(name, {31'h0, got}, {31'h0, exp});
  endtask

  task automatic check_irq();
    check_bit("irq_o", irq, |(model[3][2:0] & exp_int_stat));
  endtask

  task automatic check_outputs();
    check_val("ctrl_o", ctrl, model[1]);
    check_val("clk_div_o", clk_div, model[5]);
    check_val("cs_ctrl_o", cs_ctrl, model[6]);
    check_val("cmd_cfg_o", cmd_cfg, model[7]);
    check_val("cmd_op_o", cmd_op, model[8]);
    check_val("cmd_addr_o", cmd_addr, model[9]);
    check_val("cmd_len_o", cmd_len, model[10]);
  endtask

  // ------------------------------------------------------------
  // APB transfers entered and left on a falling edge
  // ------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    int waited;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    pstrb = strb;
    @(negedge pclk);
    penable = 1'b1;
    #1;
    waited = 0;
    while (!pready && waited < TIMEOUT_CYC) begin
      @(negedge pclk);
      #1;
      waited++;
    end
    if (!pready) begin
      fail_cnt++;
      $display("APB transfer to offset 0x%03h timed out waiting for PREADY", addr);
    end
    last_rdata = prdata;
    last_err = pslverr;
    last_tx_we = tx_we;
    last_tx_data = tx_data;
    last_rx_re = rx_re;
    @(negedge pclk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic exp_err);
    apb_xfer(1'b1, addr, data, strb);
    check_bit($sformatf("pslverr_o@%03h", addr), last_err, exp_err);
  endtask

  task automatic apb_read(input logic [11:0] addr);
    apb_xfer(1'b0, addr, 32'h0, 4'h0);
  endtask

  task automatic check_read(input logic [3:0] idx);
    apb_read({6'h0, idx, 2'b00});
    check_val($sformatf("prdata_o@%03h", {6'h0, idx, 2'b00}), last_rdata, expected_read(idx));
    check_bit("pslverr_o", last_err, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Test sequences
  // ------------------------------------------------------------
  task automatic reset_checks();
    check_bit("pslverr_o", pslverr, 1'b0);
    check_bit("cmd_start_o", cmd_start, 1'b0);
    check_bit("fifo_tx_we_o", tx_we, 1'b0);
    check_bit("fifo_rx_re_o", rx_re, 1'b0);
    check_bit("irq_o", irq, 1'b0);
    for (int i = 0; i < 14; i++) begin
      if (i != 11 && i != 12) begin
        check_read(4'(i));
      end
    end
    check_outputs();
  endtask

  task automatic random_regs();
    logic [3:0]  idx;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int n = 0; n < 40; n++) begin
      case (3'($urandom_range(7, 0)))
        3'd0: idx = 4'd1;
        3'd1: idx = 4'd3;
        3'd2: idx = 4'd5;
        3'd3: idx = 4'd6;
        3'd4: idx = 4'd7;
        3'd5: idx = 4'd8;
        3'd6: idx = 4'd9;
        default: idx = 4'd10;
      endcase
      data = $urandom;
      // Bit 8 kept clear so no command starts
      if (idx == 4'd1) data[8] = 1'b0;
      strb = 4'($urandom_range(15, 1));
      apb_write({6'h0, idx, 2'b00}, data, strb, 1'b0);
      model_write(idx, data, strb);
      check_outputs();
      check_read(idx);
    end
  endtask

  task automatic bad_writes();
    apb_write(12'h000, $urandom, 4'hF, 1'b1);
    apb_write(12'h030, $urandom, 4'hF, 1'b1);
    apb_write(12'h034, $urandom, 4'hF, 1'b1);
    apb_write(12'h038, $urandom, 4'hF, 1'b1);
    apb_write(12'hFFC, $urandom, 4'hF, 1'b1);
    check_bit("fifo_tx_we_o", last_tx_we, 1'b0);
    for (int i = 0; i < 11; i++) begin
      check_read(4'(i));
    end
    check_outputs();
  endtask

  task automatic trigger_checks();
    // Enable starts cleared so the next write must set it
    apb_write(12'h004, 32'h0000_0000, 4'hF, 1'b0);
    model_write(4'd1, 32'h0000_0000, 4'hF);

    // Enable and trigger in one transfer
    apb_write(12'h004, 32'h0000_0101, 4'hF, 1'b0);
    model_write(4'd1, 32'h0000_0101, 4'hF);
    // Start request is up in the cycle after the access phase
    check_bit("cmd_start_o", cmd_start, 1'b1);
    repeat (3) begin
      @(negedge pclk);
      check_bit("cmd_start_o", cmd_start, 1'b1);
    end
    trig_clr = 1'b1;
    check_bit("cmd_start_o", cmd_start, 1'b1);
    @(negedge pclk);
    trig_clr = 1'b0;
    check_bit("cmd_start_o", cmd_start, 1'b0);
    check_outputs();

    // Busy lockout while the cpol part of the write still lands
    busy = 1'b1;
    apb_write(12'h004, 32'h0000_0109, 4'hF, 1'b1);
    model_write(4'd1, 32'h0000_0109, 4'hF);
    repeat (4) begin
      check_bit("cmd_start_o", cmd_start, 1'b0);
      @(negedge pclk);
    end
    busy = 1'b0;
    check_read(4'd1);

    // Trigger with enable cleared by the same write
    apb_write(12'h004, 32'h0000_0100, 4'hF, 1'b0);
    model_write(4'd1, 32'h0000_0100, 4'hF);
    repeat (4) begin
      check_bit("cmd_start_o", cmd_start, 1'b0);
      @(negedge pclk);
    end
    check_outputs();
  endtask

  task automatic pulse_event(input logic [2:0] which);
    events.cmd_done_set = which[0];
    events.tx_empty_set = which[1];
    events.rx_full_set = which[2];
    @(negedge pclk);
    events = '0;
    exp_int_stat = exp_int_stat | which;
    if (which[0]) exp_done = 1'b1;
  endtask

  task automatic event_checks();
    apb_write(12'h00C, 32'h0000_0005, 4'h1, 1'b0);
    model_write(4'd3, 32'h0000_0005, 4'h1);
    check_irq();
    pulse_event(3'b001);
    check_irq();
    check_read(4'd4);
    check_read(4'd2);
    pulse_event(3'b010);
    pulse_event(3'b100);
    check_irq();
    check_read(4'd4);

    // Write-one-to-clear
    apb_write(12'h010, 32'h0000_0001, 4'h1, 1'b0);
    exp_int_stat[0] = 1'b0;
    check_irq();
    check_read(4'd4);

    // Set in the same cycle as a clear wins
    events.rx_full_set = 1'b1;
    apb_write(12'h010, 32'h0000_0004, 4'h1, 1'b0);
    events = '0;
    check_irq();
    check_read(4'd4);

    apb_write(12'h010, 32'h0000_0007, 4'hF, 1'b0);
    exp_int_stat = 3'b000;
    check_irq();
    check_read(4'd4);

    // Done latch clears only through byte 0
    apb_write(12'h008, 32'h0000_0101, 4'h2, 1'b0);
    check_read(4'd2);
    apb_write(12'h008, 32'h0000_0001, 4'h1, 1'b0);
    exp_done = 1'b0;
    check_read(4'd2);
  endtask

  task automatic fifo_checks();
    logic [31:0] data;
    data = $urandom;
    apb_write(12'h02C, data, 4'hF, 1'b0);
    check_bit("fifo_tx_we_o", last_tx_we, 1'b1);
    check_val("fifo_tx_data_o", last_tx_data, data);

    rx_data = $urandom;
    for (int i = 0; i < 3; i++) begin
      check_read(4'd12);
      check_bit("fifo_rx_re_o", last_rx_re, (i == 0));
    end
    check_read(4'd1);
    rx_data = $urandom;
    check_read(4'd12);
    check_bit("fifo_rx_re_o", last_rx_re, 1'b1);

    busy = 1'b1;
    for (int i = 0; i < 3; i++) begin
      fifo_st = fifo_status_t'(10'($urandom));
      check_read(4'd2);
      check_read(4'd13);
    end
    busy = 1'b0;
  endtask

  initial begin
    void'($urandom(18894));
    pclk = 1'b0;
    presetn = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 12'h0;
    pwdata = 32'h0;
    pstrb = 4'h0;
    busy = 1'b0;
    trig_clr = 1'b0;
    events = '0;
    fifo_st = '0;
    rx_data = 32'h0;
    mismatch_cnt = 0;
    fail_cnt = 0;
    model_reset();
    repeat (4) @(posedge pclk);
    @(negedge pclk);
    presetn = 1'b1;
    @(negedge pclk);

    reset_checks();
    random_regs();
    bad_writes();
    trigger_checks();
    event_checks();
    fifo_checks();
    repeat (2) @(negedge pclk);

    $display("Errors: mismatches=%0d failures=%0d", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
qspi_csr_pkg.sv
apb_decode.sv
csr_field_reg.sv
ctrl_trigger.sv
event_status.sv
read_return.sv
qspi_csr_top.sv
tb_qspi_csr.sv

//--- Makefile
TOP = tb_qspi_csr

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
